//--- src/mont_pkg.sv
package mont_pkg;

    // operand width, one radix-4 digit consumed per iteration
    localparam int OPERAND_W = 64;

    // headroom for sum + 3B + 3M and a sign bit for the trial subtraction
    localparam int ACC_W = OPERAND_W + 3;

    localparam int ITER_N = OPERAND_W / 2;

    // counter must be able to hold ITER_N itself
    localparam int CNT_W = $clog2(ITER_N + 1);

    typedef logic [OPERAND_W-1:0] operand_t;

    typedef logic [ACC_W-1:0] acc_t;

    typedef logic [1:0] digit_t;

    // multiple selection
    typedef enum logic [2:0] {
        sel_zero = 3'd0,
        sel_b    = 3'd1,
        sel_2b   = 3'd2,
        sel_3b   = 3'd3,
        sel_m    = 3'd4,
        sel_2m   = 3'd5,
        sel_3m   = 3'd6
    } mult_sel_e;

    // controller states
    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_add_b,
        st_add_m,
        st_final,
        st_done
    } mont_state_e;

    // datapath commands, one bundle shared by all datapath blocks
    typedef struct packed {
        // capture operands, clear the sum
        logic      load;
        // sum += selected multiple
        logic      add_en;
        // sum = (sum + multiple) >> 2, A >> 2
        logic      shift_en;
        // trial subtraction into the result register
        logic      final_en;
        mult_sel_e sel;
    } mont_ctrl_t;

endpackage

//--- src/multiple_table.sv
`timescale 1ns/1ps

module multiple_table import mont_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  mont_ctrl_t ctrl,
    input  operand_t   b,
    input  operand_t   m,
    output acc_t       multiple
);

    operand_t b_q;
    operand_t m_q;
    acc_t     b3_q;
    acc_t     m3_q;

    acc_t b_ext;
    acc_t m_ext;
    acc_t b2;
    acc_t m2;
    acc_t b3_next;
    acc_t m3_next;

    // 3x computed once at load, used for every iteration
    assign b3_next = {3'b000, b} + {2'b00, b, 1'b0};
    assign m3_next = {3'b000, m} + {2'b00, m, 1'b0};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            b_q  <= '0;
            m_q  <= '0;
            b3_q <= '0;
            m3_q <= '0;
        end else if (ctrl.load) begin
            b_q  <= b;
            m_q  <= m;
            b3_q <= b3_next;
            m3_q <= m3_next;
        end
    end

    assign b_ext = {3'b000, b_q};
    assign m_ext = {3'b000, m_q};

    // 2x is just a wired shift
    assign b2 = {2'b00, b_q, 1'b0};
    assign m2 = {2'b00, m_q, 1'b0};

    always_comb begin
        case (ctrl.sel)
            sel_b:   multiple = b_ext;
            sel_2b:  multiple = b2;
            sel_3b:  multiple = b3_q;
            sel_m:   multiple = m_ext;
            sel_2m:  multiple = m2;
            sel_3m:  multiple = m3_q;
            default: multiple = '0;
        endcase
    end

endmodule

//--- src/digit_shifter.sv
`timescale 1ns/1ps

module digit_shifter import mont_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  mont_ctrl_t ctrl,
    input  operand_t   a,
    output digit_t     a_digit
);

    operand_t a_q;

    // A is consumed from the bottom, two bits per iteration
    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_q <= '0;
        end else if (ctrl.load) begin
            a_q <= a;
        end else if (ctrl.shift_en) begin
            a_q <= a_q >> 2;
        end
    end

    // current radix-4 digit for the B multiple select
    assign a_digit = a_q[1:0];

endmodule

//--- src/accumulator.sv
`timescale 1ns/1ps

module accumulator import mont_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  mont_ctrl_t ctrl,
    input  acc_t       multiple,
    input  operand_t   m,
    output digit_t     acc_low,
    output operand_t   result
);

    acc_t     sum_q;
    acc_t     sum_add;
    acc_t     sum_diff;
    operand_t result_q;
    logic     diff_neg;

    // single-cycle add of the selected multiple
    assign sum_add = sum_q + multiple;

    // trial subtraction, sum stays below 2m so one pass is enough
    assign sum_diff = sum_q - {3'b000, m};
    assign diff_neg = sum_diff[ACC_W-1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            sum_q <= '0;
        end else if (ctrl.load) begin
            sum_q <= '0;
        end else if (ctrl.shift_en) begin
            // low two bits are zero here, so the shift is an exact divide by 4
            sum_q <= sum_add >> 2;
        end else if (ctrl.add_en) begin
            sum_q <= sum_add;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result_q <= '0;
        end else if (ctrl.final_en) begin
            if (diff_neg) begin
                result_q <= sum_q[OPERAND_W-1:0];
            end else begin
                result_q <= sum_diff[OPERAND_W-1:0];
            end
        end
    end

    // controller derives the quotient digit from these
    assign acc_low = sum_q[1:0];
    assign result  = result_q;

    // quotient digit chosen by the controller must clear the low digit
    a_shift_exact: assert property (
        @(posedge clk) disable iff (!resetn)
        ctrl.shift_en |-> (sum_add[1:0] == 2'b00)
    );

endmodule

//--- src/mont_control.sv
`timescale 1ns/1ps

module mont_control import mont_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  digit_t     m_low,
    input  digit_t     a_digit,
    input  digit_t     acc_low,
    output mont_ctrl_t ctrl,
    output logic       done
);

    mont_state_e state;
    mont_state_e state_next;

    logic [CNT_W-1:0] iter_cnt;
    logic             last_iter;

    digit_t q_prod;
    digit_t q_digit;

    logic done_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    assign last_iter = (iter_cnt == CNT_W'(ITER_N - 1));

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_load;
                end
            end
            st_load:  state_next = st_add_b;
            st_add_b: state_next = st_add_m;
            st_add_m: begin
                if (last_iter) begin
                    state_next = st_final;
                end else begin
                    state_next = st_add_b;
                end
            end
            st_final: state_next = st_done;
            st_done:  state_next = st_idle;
            default:  state_next = st_idle;
        endcase
    end

    // one count per finished iteration
    always_ff @(posedge clk) begin
        if (!resetn) begin
            iter_cnt <= '0;
        end else if (state == st_load) begin
            iter_cnt <= '0;
        end else if (state == st_add_m) begin
            iter_cnt <= iter_cnt + 1'b1;
        end
    end

    // q = -(s * m^-1) mod 4, and m^-1 == m mod 4 for odd m
    assign q_prod  = digit_t'(acc_low * m_low);
    assign q_digit = digit_t'(~q_prod + 2'd1);

    always_comb begin
        ctrl = '{load: 1'b0, add_en: 1'b0, shift_en: 1'b0, final_en: 1'b0, sel: sel_zero};
        case (state)
            st_load: ctrl.load = 1'b1;
            st_add_b: begin
                ctrl.add_en = 1'b1;
                case (a_digit)
                    2'd1:    ctrl.sel = sel_b;
                    2'd2:    ctrl.sel = sel_2b;
                    2'd3:    ctrl.sel = sel_3b;
                    default: ctrl.sel = sel_zero;
                endcase
            end
            st_add_m: begin
                // add q*M and divide by 4 in the same cycle
                ctrl.shift_en = 1'b1;
                case (q_digit)
                    2'd1:    ctrl.sel = sel_m;
                    2'd2:    ctrl.sel = sel_2m;
                    2'd3:    ctrl.sel = sel_3m;
                    default: ctrl.sel = sel_zero;
                endcase
            end
            st_final: ctrl.final_en = 1'b1;
            default: ;
        endcase
    end

    // registered so done lands one cycle after the st_done edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            done_q <= 1'b0;
        end else begin
            done_q <= (state == st_done);
        end
    end

    assign done = done_q;

    a_cnt_range: assert property (
        @(posedge clk) disable iff (!resetn)
        iter_cnt <= CNT_W'(ITER_N)
    );

    // Montgomery reduction only works for an odd modulus
    a_m_odd: assert property (
        @(posedge clk) disable iff (!resetn)
        (state == st_idle && start) |-> m_low[0]
    );

endmodule

//--- src/montgomery_top.sv
`timescale 1ns/1ps

module montgomery_top import mont_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     start,
    input  operand_t a,
    input  operand_t b,
    input  operand_t m,
    output operand_t result,
    output logic     done
);

    mont_ctrl_t ctrl;
    acc_t       multiple;
    digit_t     a_digit;
    digit_t     acc_low;
    digit_t     m_low;

    // modulus low digit for quotient selection
    assign m_low = m[1:0];

    mont_control u_control (
        .clk     (clk),
        .resetn  (resetn),
        .start   (start),
        .m_low   (m_low),
        .a_digit (a_digit),
        .acc_low (acc_low),
        .ctrl    (ctrl),
        .done    (done)
    );

    multiple_table u_table (
        .clk      (clk),
        .resetn   (resetn),
        .ctrl     (ctrl),
        .b        (b),
        .m        (m),
        .multiple (multiple)
    );

    digit_shifter u_shifter (
        .clk     (clk),
        .resetn  (resetn),
        .ctrl    (ctrl),
        .a       (a),
        .a_digit (a_digit)
    );

    accumulator u_acc (
        .clk      (clk),
        .resetn   (resetn),
        .ctrl     (ctrl),
        .multiple (multiple),
        .m        (m),
        .acc_low  (acc_low),
        .result   (result)
    );

endmodule

//--- verif/tb_montgomery.sv
`timescale 1ns/1ps

module tb_montgomery import mont_pkg::*; ();

    typedef struct packed {
        operand_t a;
        operand_t b;
        operand_t m;
    } vec_t;

    localparam int N_FIXED = 8;
    localparam int N_RAND  = 12;
    localparam int N_ROWS  = N_FIXED + N_RAND;
    localparam int LATENCY = OPERAND_W + 3;
    // table rows, the busy job and some margin for reset
    localparam int WATCHDOG_CYCLES = (N_ROWS + 3) * (OPERAND_W + 10);

    logic     clk;
    logic     resetn;
    logic     start;
    operand_t a;
    operand_t b;
    operand_t m;
    operand_t result;
    logic     done;

    vec_t vectors [N_ROWS];

    int err_cnt;
    int pass_cnt;
    int fail_cnt;
    int done_cnt;
    int sub_rows;
    int plain_rows;

    montgomery_top dut (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .result (result),
        .done   (done)
    );

    always #10 clk = ~clk;

    // every done pulse seen by the testbench
    always @(posedge clk) begin
        if (resetn && done) begin
            done_cnt = done_cnt + 1;
        end
    end

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // bit-serial Montgomery product, a*b*2^-OPERAND_W mod m
    function automatic operand_t ref_montmul(input operand_t ra, input operand_t rb,
                                             input operand_t rm);
        logic [OPERAND_W+1:0] s;
        s = '0;
        for (int i = 0; i < OPERAND_W; i++) begin
            if (ra[i]) begin
                s = s + {2'b00, rb};
            end
            if (s[0]) begin
                s = s + {2'b00, rm};
            end
            s = s >> 1;
        end
        if (s >= {2'b00, rm}) begin
            s = s - {2'b00, rm};
        end
        return s[OPERAND_W-1:0];
    endfunction

    task automatic build_table();
        operand_t rm;
        operand_t ra;
        operand_t rb;
        vectors[0] = '{a: 64'd3, b: 64'd5, m: 64'd7};
        // zero operands
        vectors[1] = '{a: 64'd0, b: 64'd12345, m: 64'd1000003};
        vectors[2] = '{a: 64'd987654, b: 64'd0, m: 64'd1000003};
        // moduli close to 2^64
        vectors[3] = '{a: 64'hFFFF_FFFF_FFFF_FFC4, b: 64'hFFFF_FFFF_FFFF_FFC3,
                       m: 64'hFFFF_FFFF_FFFF_FFC5};
        vectors[4] = '{a: 64'hFFFF_FFFF_FFFF_FFFE, b: 64'hFFFF_FFFF_FFFF_FFFD,
                       m: 64'hFFFF_FFFF_FFFF_FFFF};
        vectors[5] = '{a: 64'h7FFF_FFFF_0000_0001, b: 64'h8000_0000_0000_0000,
                       m: 64'h8000_0000_0000_0001};
        // small moduli
        vectors[6] = '{a: 64'd12, b: 64'd11, m: 64'd13};
        vectors[7] = '{a: 64'd0, b: 64'd0, m: 64'd1};
        for (int i = N_FIXED; i < N_ROWS; i++) begin
            rm = {$urandom(), $urandom()};
            if (i % 3 == 0) begin
                rm = rm & 64'h000F_FFFF;
            end else if (i % 3 == 1) begin
                rm[OPERAND_W-1] = 1'b1;
            end
            rm[0] = 1'b1;
            ra = {$urandom(), $urandom()};
            rb = {$urandom(), $urandom()};
            vectors[i] = '{a: ra % rm, b: rb % rm, m: rm};
        end
    endtask

    // one job; busy_at > 0 adds a stray start that many edges into the job
    task automatic run_job(input vec_t v, input int busy_at, output operand_t res,
                           output int edges);
        @(posedge clk);
        #2;
        a     = v.a;
        b     = v.b;
        m     = v.m;
        start = 1'b1;
        // edge 0 samples start
        @(posedge clk);
        #2;
        start = 1'b0;
        edges = 0;
        while (!done) begin
            @(posedge clk);
            #2;
            edges++;
            if (edges == busy_at) begin
                start = 1'b1;
                a     = ~v.a;
                b     = ~v.b;
            end else begin
                start = 1'b0;
            end
        end
        res = result;
    endtask

    task automatic apply_row(input int idx, input vec_t v, input int busy_at);
        operand_t got;
        operand_t exp;
        int       edges;
        int       err_before;
        int       cnt_before;
        err_before = err_cnt;
        cnt_before = done_cnt;
        exp = ref_montmul(v.a, v.b, v.m);
        run_job(v, busy_at, got, edges);
        check_value(got, exp, "montgomery product");
        check_value(edges, LATENCY, "done latency in edges");
        if (v.a == '0 || v.b == '0) begin
            check_value(got, '0, "zero operand result");
        end
        // the sum before subtraction is still held after done
        if (dut.u_acc.sum_q >= {3'b000, v.m}) begin
            sub_rows++;
        end else begin
            plain_rows++;
        end
        repeat (3) @(posedge clk);
        #2;
        check_value(result, got, "result held after done");
        check_value(done_cnt - cnt_before, 1, "done pulses per job");
        if (err_cnt == err_before) begin
            pass_cnt++;
            $display("test %0d ok: a=%h b=%h m=%h result=%h", idx, v.a, v.b, v.m, got);
        end else begin
            fail_cnt++;
            $display("test %0d mismatch: a=%h b=%h m=%h result=%h", idx, v.a, v.b, v.m, got);
        end
    endtask

    initial begin
        operand_t prev;
        vec_t     busy_vec;
        clk        = 1'b0;
        resetn     = 1'b0;
        start      = 1'b0;
        a          = '0;
        b          = '0;
        m          = '0;
        err_cnt    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        done_cnt   = 0;
        sub_rows   = 0;
        plain_rows = 0;
        void'($urandom(32'h8969ca1b));
        build_table();

        repeat (2) @(posedge clk);
        #2;
        resetn = 1'b1;
        check_value(done, 1'b0, "done low after reset");

        prev = result;
        for (int i = 0; i < N_ROWS; i++) begin
            // idle gap before the next start
            @(posedge clk);
            #2;
            check_value(result, prev, "result held until next start");
            apply_row(i, vectors[i], 0);
            prev = result;
        end

        // stray start in the middle of a job
        busy_vec = '{a: 64'h1234_5678_9ABC_DEF0, b: 64'h0FED_CBA9_8765_4321,
                     m: 64'hFFFF_FFFF_FFFF_FFC5};
        apply_row(N_ROWS, busy_vec, 20);

        check_value(sub_rows > 0, 1'b1, "no row took the subtraction path");
        check_value(plain_rows > 0, 1'b1, "no row skipped the subtraction");

        $display("tests: %0d ok, %0d mismatched, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: done never arrived within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- build.f
src/mont_pkg.sv
src/multiple_table.sv
src/digit_shifter.sv
src/accumulator.sv
src/mont_control.sv
src/montgomery_top.sv
verif/tb_montgomery.sv

//--- Makefile
SIM  := obj_dir/Vtb_montgomery
SRCS := $(wildcard src/*.sv) verif/tb_montgomery.sv

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_montgomery -o Vtb_montgomery

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir
